// ==== Bender.yml ====
package:
  name: core

sources:
  - source/core_pkg.sv
  - source/register_file.sv
  - source/instruction_memory.sv
  - source/fetch_stage.sv
  - source/decode_stage.sv
  - source/execute_stage.sv
  - source/core_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/core_tb.sv

// ==== all.f ====
+incdir+test
source/core_pkg.sv
source/register_file.sv
source/instruction_memory.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/core_top.sv
test/core_tb.sv

// ==== source/core_pkg.sv ====
// word and register index types, opcode, ALU operation and instruction kind enums
package core_pkg;

    typedef logic [31:0] word_t;    // instruction, address or data word
    typedef logic [4:0]  reg_idx_t; // architectural register number

    // major opcodes of the RV32I subset, standard encoding values
    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        SYSTEM = 7'b1110011
    } opcode_e;

    // operations the execute ALU knows about
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,    // signed compare, result is 0 or 1
        ALU_PASS_B  // second operand straight through, used by LUI
    } alu_op_e;

    // what execute does with a decoded instruction besides the ALU result
    typedef enum logic [2:0] {
        KIND_ALU,
        KIND_BEQ,
        KIND_BNE,
        KIND_JAL,
        KIND_ECALL,
        KIND_NOP    // anything unsupported retires without a write
    } inst_kind_e;

endpackage

// ==== source/core_top.sv ====
// three-stage core with instruction memory, fetch, decode and execute
`timescale 1ns/1ns

module core_top import core_pkg::*; #(
    parameter word_t BOOT_BASE = 32'h0,
    parameter word_t TRAP_BASE = 32'h80,
    parameter int    MEM_WORDS = 64
) (
    input  logic     aclk,
    input  logic     aresetn,
    input  logic     prog_we,
    input  word_t    prog_addr,
    input  word_t    prog_data,
    output logic     retire_valid,
    output word_t    retire_pc,
    output reg_idx_t retire_rd,
    output word_t    retire_data
);

    // memory read channel
    logic  ar_valid;
    word_t ar_addr;
    logic  ar_ready;
    logic  r_valid;
    word_t r_data;
    logic  r_ready;

    // fetch to decode
    logic  f_valid;
    word_t f_pc;
    word_t f_ir;
    logic  f_ready;

    // decode to execute
    logic       d_valid;
    logic       d_ready;
    word_t      d_pc;
    inst_kind_e d_kind;
    alu_op_e    d_alu_op;
    reg_idx_t   d_rs1;
    reg_idx_t   d_rs2;
    reg_idx_t   d_rd;
    word_t      d_imm;
    logic       d_use_imm;

    // redirect from execute
    logic  branch;
    logic  trap;
    word_t target;
    logic  flush;

    instruction_memory #(
        .MEM_WORDS (MEM_WORDS)
    ) u_imem (
        .aclk, .aresetn, .prog_we, .prog_addr, .prog_data,
        .ar_valid, .ar_addr, .ar_ready, .r_valid, .r_data, .r_ready
    );

    fetch_stage #(
        .BOOT_BASE (BOOT_BASE),
        .TRAP_BASE (TRAP_BASE)
    ) u_fetch (
        .aclk, .aresetn, .branch, .target, .trap,
        .ar_valid, .ar_addr, .ar_ready, .r_valid, .r_data, .r_ready,
        .f_valid, .f_pc, .f_ir, .f_ready
    );

    decode_stage u_decode (
        .aclk, .aresetn, .flush, .f_valid, .f_pc, .f_ir, .f_ready,
        .d_valid, .d_ready, .d_pc, .d_kind, .d_alu_op,
        .d_rs1, .d_rs2, .d_rd, .d_imm, .d_use_imm
    );

    execute_stage u_execute (
        .aclk, .aresetn, .d_valid, .d_ready, .d_pc, .d_kind, .d_alu_op,
        .d_rs1, .d_rs2, .d_rd, .d_imm, .d_use_imm,
        .branch, .trap, .target, .flush,
        .retire_valid, .retire_pc, .retire_rd, .retire_data
    );

endmodule

// ==== source/decode_stage.sv ====
// registered decode of fetched words into operation, register indices and immediate
`timescale 1ns/1ns

module decode_stage import core_pkg::*; (
    input  logic       aclk,
    input  logic       aresetn,
    input  logic       flush,
    input  logic       f_valid,
    input  word_t      f_pc,
    input  word_t      f_ir,
    output logic       f_ready,
    output logic       d_valid,
    input  logic       d_ready,
    output word_t      d_pc,
    output inst_kind_e d_kind,
    output alu_op_e    d_alu_op,
    output reg_idx_t   d_rs1,
    output reg_idx_t   d_rs2,
    output reg_idx_t   d_rd,
    output word_t      d_imm,
    output logic       d_use_imm
);

    inst_kind_e dec_kind;
    alu_op_e    dec_alu_op;
    reg_idx_t   dec_rd;
    word_t      dec_imm;
    logic       dec_use_imm;

    wire [2:0] funct3 = f_ir[14:12];
    wire [6:0] funct7 = f_ir[31:25];

    // the register can always refill when it is empty, draining or being flushed
    assign f_ready = ~d_valid | d_ready | flush;

    always_comb begin
        dec_kind    = KIND_NOP;
        dec_alu_op  = ALU_ADD;
        dec_rd      = '0;       // only writing kinds keep their rd
        dec_imm     = '0;
        dec_use_imm = 1'b0;
        case (opcode_e'(f_ir[6:0]))
            OP_IMM: begin
                dec_imm     = {{20{f_ir[31]}}, f_ir[31:20]};
                dec_use_imm = 1'b1;
                if (funct3 == 3'b000) begin // ADDI
                    dec_kind = KIND_ALU;
                    dec_rd   = f_ir[11:7];
                end
            end
            OP: begin
                dec_kind = KIND_ALU;
                dec_rd   = f_ir[11:7];
                case ({funct7, funct3})
                    10'b0000000_000: dec_alu_op = ALU_ADD;
                    10'b0100000_000: dec_alu_op = ALU_SUB;
                    10'b0000000_111: dec_alu_op = ALU_AND;
                    10'b0000000_110: dec_alu_op = ALU_OR;
                    10'b0000000_100: dec_alu_op = ALU_XOR;
                    10'b0000000_010: dec_alu_op = ALU_SLT;
                    default: begin
                        dec_kind = KIND_NOP;
                        dec_rd   = '0;
                    end
                endcase
            end
            LUI: begin
                dec_kind    = KIND_ALU;
                dec_alu_op  = ALU_PASS_B;
                dec_rd      = f_ir[11:7];
                dec_imm     = {f_ir[31:12], 12'b0};
                dec_use_imm = 1'b1;
            end
            BRANCH: begin
                dec_imm = {{19{f_ir[31]}}, f_ir[31], f_ir[7], f_ir[30:25], f_ir[11:8], 1'b0};
                if (funct3 == 3'b000) dec_kind = KIND_BEQ;
                if (funct3 == 3'b001) dec_kind = KIND_BNE;
            end
            JAL: begin
                dec_kind = KIND_JAL;
                dec_rd   = f_ir[11:7];
                dec_imm  = {{11{f_ir[31]}}, f_ir[31], f_ir[19:12], f_ir[20], f_ir[30:21], 1'b0};
            end
            SYSTEM: begin
                if (f_ir[31:7] == '0) dec_kind = KIND_ECALL; // exactly the ECALL word
            end
            default: ;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!aresetn || flush) begin
            d_valid <= 1'b0;
        end else if (f_valid && f_ready) begin
            d_valid <= 1'b1;
        end else if (d_ready) begin
            d_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (f_valid && f_ready) begin
            d_pc      <= f_pc;
            d_kind    <= dec_kind;
            d_alu_op  <= dec_alu_op;
            d_rs1     <= f_ir[19:15];
            d_rs2     <= f_ir[24:20];
            d_rd      <= dec_rd;
            d_imm     <= dec_imm;
            d_use_imm <= dec_use_imm;
        end
    end

    a_hold_valid: assert property (@(posedge aclk) disable iff (!aresetn)
        d_valid && !d_ready && !flush |=> d_valid);

endmodule

// ==== source/execute_stage.sv ====
// ALU, branch and jump resolution, ECALL trap, register write-back and retire report
`timescale 1ns/1ns

module execute_stage import core_pkg::*; (
    input  logic       aclk,
    input  logic       aresetn,
    input  logic       d_valid,
    output logic       d_ready,
    input  word_t      d_pc,
    input  inst_kind_e d_kind,
    input  alu_op_e    d_alu_op,
    input  reg_idx_t   d_rs1,
    input  reg_idx_t   d_rs2,
    input  reg_idx_t   d_rd,
    input  word_t      d_imm,
    input  logic       d_use_imm,
    output logic       branch,
    output logic       trap,
    output word_t      target,
    output logic       flush,
    output logic       retire_valid,
    output word_t      retire_pc,
    output reg_idx_t   retire_rd,
    output word_t      retire_data
);

    word_t rdata_a;
    word_t rdata_b;
    word_t op_b;
    word_t alu_res;
    word_t wr_data;
    logic  taken;
    logic  writes;

    wire xfer = d_valid & d_ready;

    // nothing is accepted while a redirect is on its way to fetch
    assign d_ready = ~(branch | trap);
    assign flush   = branch | trap;

    register_file u_regs (
        .aclk    (aclk),
        .we      (xfer & writes),
        .waddr   (d_rd),
        .wdata   (wr_data),
        .raddr_a (d_rs1),
        .raddr_b (d_rs2),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b)
    );

    assign op_b = d_use_imm ? d_imm : rdata_b;

    always_comb begin
        case (d_alu_op)
            ALU_ADD:    alu_res = rdata_a + op_b;
            ALU_SUB:    alu_res = rdata_a - op_b;
            ALU_AND:    alu_res = rdata_a & op_b;
            ALU_OR:     alu_res = rdata_a | op_b;
            ALU_XOR:    alu_res = rdata_a ^ op_b;
            ALU_SLT:    alu_res = {31'b0, $signed(rdata_a) < $signed(op_b)};
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    assign writes  = (d_kind == KIND_ALU) || (d_kind == KIND_JAL);
    assign wr_data = (d_kind == KIND_JAL) ? d_pc + 32'd4 : alu_res; // link address for JAL

    always_comb begin
        case (d_kind)
            KIND_BEQ: taken = (rdata_a == rdata_b);
            KIND_BNE: taken = (rdata_a != rdata_b);
            KIND_JAL: taken = 1'b1;
            default:  taken = 1'b0;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            branch       <= 1'b0;
            trap         <= 1'b0;
            retire_valid <= 1'b0;
        end else begin
            branch       <= xfer & taken;
            trap         <= xfer & (d_kind == KIND_ECALL);
            retire_valid <= xfer; // one pulse per completed instruction
        end
    end

    always_ff @(posedge aclk) begin
        if (xfer) begin
            target      <= d_pc + d_imm;
            retire_pc   <= d_pc;
            retire_rd   <= d_rd;
            // a write to x0 is discarded, so it reports zero
            retire_data <= (writes && d_rd != '0) ? wr_data : '0;
        end
    end

    a_one_redirect: assert property (@(posedge aclk) disable iff (!aresetn)
        !(branch && trap));

endmodule

// ==== source/fetch_stage.sv ====
// program counter, redirection on branch and trap, and instruction memory read requests
`timescale 1ns/1ns

module fetch_stage import core_pkg::*; #(
    parameter word_t BOOT_BASE = 32'h0,
    parameter word_t TRAP_BASE = 32'h80
) (
    input  logic  aclk,
    input  logic  aresetn,
    input  logic  branch,
    input  word_t target,
    input  logic  trap,
    output logic  ar_valid,
    output word_t ar_addr,
    input  logic  ar_ready,
    input  logic  r_valid,
    input  word_t r_data,
    output logic  r_ready,
    output logic  f_valid,
    output word_t f_pc,
    output word_t f_ir,
    input  logic  f_ready
);

    word_t pc;      // address of the word currently in flight
    logic  trapped; // the word in flight was requested before a redirect

    wire ar_fire = ar_valid & ar_ready;
    wire r_fire  = r_valid & r_ready;

    // fetch always prefetches the next sequential word
    assign ar_valid = 1'b1;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            ar_addr <= BOOT_BASE;
        end else if (ar_fire) begin
            if (trap) begin
                ar_addr <= TRAP_BASE; // trap outranks a branch
            end else if (branch) begin
                ar_addr <= target;
            end else begin
                ar_addr <= ar_addr + 32'd4;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            pc <= BOOT_BASE;
        end else if (ar_fire) begin
            pc <= ar_addr; // pairs the PC with the data that comes back
        end
    end

    // the request issued on the redirect edge is stale, so drop its data
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            trapped <= 1'b0;
        end else if (branch || trap) begin
            trapped <= 1'b1;
        end else if (r_fire) begin
            trapped <= 1'b0;
        end
    end

    assign r_ready = f_ready;
    assign f_valid = r_valid & ~branch & ~trap & ~trapped;
    assign f_pc    = pc;
    assign f_ir    = r_data;

    a_addr_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        ar_valid && !ar_ready |=> $stable(ar_addr));

endmodule

// ==== source/instruction_memory.sv ====
// word-addressed program RAM with a load port and a one-deep read channel
`timescale 1ns/1ns

module instruction_memory import core_pkg::*; #(
    parameter int MEM_WORDS = 64
) (
    input  logic  aclk,
    input  logic  aresetn,
    input  logic  prog_we,
    input  word_t prog_addr,
    input  word_t prog_data,
    input  logic  ar_valid,
    input  word_t ar_addr,
    output logic  ar_ready,
    output logic  r_valid,
    output word_t r_data,
    input  logic  r_ready
);

    word_t mem [MEM_WORDS];

    word_t wr_idx;
    word_t rd_idx;

    // byte addresses become word indices that wrap at the depth
    assign wr_idx = (prog_addr >> 2) % word_t'(MEM_WORDS);
    assign rd_idx = (ar_addr >> 2) % word_t'(MEM_WORDS);

    // a new address is taken when the output slot is free or drains this cycle
    assign ar_ready = ~r_valid | r_ready;

    always_ff @(posedge aclk) begin
        if (prog_we) begin
            mem[wr_idx] <= prog_data;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            r_valid <= 1'b0;
        end else if (ar_valid && ar_ready) begin
            r_valid <= 1'b1;
        end else if (r_ready) begin
            r_valid <= 1'b0; // data taken and nothing new behind it
        end
    end

    // the read word stays here until the consumer takes it
    always_ff @(posedge aclk) begin
        if (ar_valid && ar_ready) begin
            r_data <= mem[rd_idx];
        end
    end

endmodule

// ==== source/register_file.sv ====
// general purpose registers x1 to x31 with x0 reading zero and two read ports
`timescale 1ns/1ns

module register_file import core_pkg::*; (
    input  logic     aclk,
    input  logic     we,
    input  reg_idx_t waddr,
    input  word_t    wdata,
    input  reg_idx_t raddr_a,
    input  reg_idx_t raddr_b,
    output word_t    rdata_a,
    output word_t    rdata_b
);

    // x0 has no storage at all
    word_t regs [31:1];

    always_ff @(posedge aclk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // reads are combinational so execute sees the value written on the previous edge
    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

// ==== test/core_model.svh ====
// instruction encoders, random program generator and reference interpreter for the core testbench
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

word_t model_mem  [MEM_WORDS];   // program image, also written to the DUT
word_t model_regs [32];
word_t model_pc;

function automatic word_t enc_alu(input logic [6:0] funct7, input logic [2:0] funct3,
                                  input reg_idx_t rd, input reg_idx_t rs1, input reg_idx_t rs2);
    return {funct7, rs2, rs1, funct3, rd, OP};
endfunction

function automatic word_t enc_addi(input reg_idx_t rd, input reg_idx_t rs1, input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, OP_IMM};
endfunction

function automatic word_t enc_lui(input reg_idx_t rd, input logic [19:0] imm);
    return {imm, rd, LUI};
endfunction

// offsets are given in words and scaled to bytes here
function automatic word_t enc_branch(input logic [2:0] funct3, input reg_idx_t rs1,
                                     input reg_idx_t rs2, input int words);
    logic [12:0] off;
    off = 13'(words * 4);
    return {off[12], off[10:5], rs2, rs1, funct3, off[4:1], off[11], BRANCH};
endfunction

function automatic word_t enc_jal(input reg_idx_t rd, input int words);
    logic [20:0] off;
    off = 21'(words * 4);
    return {off[20], off[10:1], off[11], off[19:12], rd, JAL};
endfunction

function automatic int unsigned pick(inout integer seed, input int unsigned n);
    int unsigned r;
    r = $random(seed);
    return r % n;
endfunction

// registers stay within x0 to x7 so every read hits an initialised register
function automatic word_t random_inst(inout integer seed);
    int unsigned kind;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    int          words;
    kind  = pick(seed, 23);
    rd    = reg_idx_t'(pick(seed, 8));
    rs1   = reg_idx_t'(pick(seed, 8));
    rs2   = reg_idx_t'(pick(seed, 8));
    words = int'(pick(seed, 16)) - 8;
    if (words >= 0) begin
        words = words + 1; // never a jump onto itself
    end
    case (kind)
        0, 1, 2:    return enc_addi(rd, rs1, 12'(pick(seed, 4096)));
        3, 4:       return enc_alu(7'b0000000, 3'b000, rd, rs1, rs2);
        5:          return enc_alu(7'b0100000, 3'b000, rd, rs1, rs2);
        6:          return enc_alu(7'b0000000, 3'b111, rd, rs1, rs2);
        7:          return enc_alu(7'b0000000, 3'b110, rd, rs1, rs2);
        8:          return enc_alu(7'b0000000, 3'b100, rd, rs1, rs2);
        9, 10:      return enc_alu(7'b0000000, 3'b010, rd, rs1, rs2);
        11, 12:     return enc_lui(rd, 20'(pick(seed, 32'h100000)));
        13, 14, 15: return enc_branch(3'b000, rs1, rs2, words);
        16, 17, 18: return enc_branch(3'b001, rs1, rs2, words);
        19, 20:     return enc_jal(rd, words);
        21:         return {25'b0, SYSTEM};                      // ECALL at a low rate
        default:    return {12'h5a5, rs1, 3'b100, rd, OP_IMM};   // XORI is not supported
    endcase
endfunction

// words 0 to 6 load x1 to x7, the last word jumps back to address 0
task automatic gen_program(inout integer seed);
    for (int i = 0; i < MEM_WORDS; i++) begin
        if (i < 7) begin
            model_mem[i] = enc_addi(reg_idx_t'(i + 1), 5'd0, 12'(pick(seed, 4096)));
        end else if (i == MEM_WORDS - 1) begin
            model_mem[i] = enc_jal(5'd0, 1 - MEM_WORDS);
        end else begin
            model_mem[i] = random_inst(seed);
        end
    end
endtask

task automatic model_reset();
    for (int r = 1; r < 32; r++) begin
        model_regs[r] = 'x; // undefined until the program writes it
    end
    model_regs[0] = '0;
    model_pc      = BOOT_BASE;
endtask

// executes one instruction and returns what the core should report for it
task automatic model_step(output word_t exp_pc, output reg_idx_t exp_rd, output word_t exp_data);
    word_t    ir;
    word_t    a;
    word_t    b;
    word_t    val;
    word_t    next_pc;
    logic     wr;
    ir      = model_mem[(model_pc >> 2) % word_t'(MEM_WORDS)];
    a       = model_regs[ir[19:15]];
    b       = model_regs[ir[24:20]];
    val     = '0;
    wr      = 1'b0;
    next_pc = model_pc + 32'd4;
    case (ir[6:0])
        OP_IMM: begin
            if (ir[14:12] == 3'b000) begin
                wr  = 1'b1;
                val = a + {{20{ir[31]}}, ir[31:20]};
            end
        end
        OP: begin
            wr = 1'b1;
            if (ir[31:25] == 7'b0100000 && ir[14:12] == 3'b000) val = a - b;
            else if (ir[31:25] != 7'b0000000) wr = 1'b0;
            else if (ir[14:12] == 3'b000) val = a + b;
            else if (ir[14:12] == 3'b111) val = a & b;
            else if (ir[14:12] == 3'b110) val = a | b;
            else if (ir[14:12] == 3'b100) val = a ^ b;
            else if (ir[14:12] == 3'b010) val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            else wr = 1'b0;
        end
        LUI: begin
            wr  = 1'b1;
            val = {ir[31:12], 12'b0};
        end
        BRANCH: begin
            if ((ir[14:12] == 3'b000 && a == b) || (ir[14:12] == 3'b001 && a != b)) begin
                next_pc = model_pc + {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
            end
        end
        JAL: begin
            wr      = 1'b1;
            val     = model_pc + 32'd4;
            next_pc = model_pc + {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
        end
        SYSTEM: begin
            if (ir[31:7] == '0) next_pc = TRAP_BASE;
        end
        default: ;
    endcase
    exp_pc   = model_pc;
    exp_rd   = wr ? ir[11:7] : 5'd0;
    exp_data = (wr && exp_rd != 5'd0) ? val : 32'd0; // x0 keeps reading zero
    if (exp_rd != 5'd0) begin
        model_regs[exp_rd] = val;
    end
    model_pc = next_pc;
endtask

`endif

// ==== test/core_tb.sv ====
// testbench for the core with clock, reset, program loading, retire checking and timeouts
`timescale 1ns/1ns

module core_tb import core_pkg::*; ();

    localparam word_t BOOT_BASE    = 32'h0;
    localparam word_t TRAP_BASE    = 32'h80;
    localparam int    MEM_WORDS    = 64;
    localparam int    RESET_CYCLES = 16;
    localparam int    RETIRE_COUNT = 400;
    localparam int    TIMEOUT      = 200;

    logic     aclk = 1'b0;
    logic     aresetn;
    logic     prog_we;
    word_t    prog_addr;
    word_t    prog_data;
    logic     retire_valid;
    word_t    retire_pc;
    reg_idx_t retire_rd;
    word_t    retire_data;

    integer seed;
    int     redirects;   // retirements whose successor is not at pc+4

    `include "core_model.svh"

    core_top #(
        .BOOT_BASE (BOOT_BASE),
        .TRAP_BASE (TRAP_BASE),
        .MEM_WORDS (MEM_WORDS)
    ) core_top_inst (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .prog_we      (prog_we),
        .prog_addr    (prog_addr),
        .prog_data    (prog_data),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    always #10 aclk = ~aclk;

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            $display("Test failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // outputs change on the rising edge, so they are sampled on the falling one
    task automatic wait_retire();
        int cycles;
        cycles = 0;
        @(negedge aclk);
        while (retire_valid !== 1'b1) begin
            cycles++;
            if (cycles >= TIMEOUT) begin
                $display("no instruction retired within %0d cycles", TIMEOUT);
                $display("Test failed");
                $fatal(1, "retire timeout");
            end
            @(negedge aclk);
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < MEM_WORDS; i++) begin
            @(posedge aclk);
            #2;
            prog_we   = 1'b1;
            prog_addr = word_t'(i) << 2;
            prog_data = model_mem[i];
        end
        @(posedge aclk);
        #2;
        prog_we = 1'b0;
    endtask

    initial begin
        word_t    exp_pc;
        reg_idx_t exp_rd;
        word_t    exp_data;
        aresetn   = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        seed      = 32'hde60;
        redirects = 0;
        gen_program(seed);
        model_reset();
        load_program();   // the core sits in reset while memory fills
        repeat (RESET_CYCLES) @(posedge aclk);
        @(negedge aclk);
        check_value("retire_valid in reset", 32'd0, word_t'(retire_valid));
        @(posedge aclk);
        #2;
        aresetn = 1'b1;
        for (int n = 0; n < RETIRE_COUNT; n++) begin
            wait_retire();
            model_step(exp_pc, exp_rd, exp_data);
            check_value($sformatf("retire %0d pc", n), exp_pc, retire_pc);
            check_value($sformatf("retire %0d rd", n), word_t'(exp_rd), word_t'(retire_rd));
            check_value($sformatf("retire %0d data", n), exp_data, retire_data);
            if (model_pc != exp_pc + 32'd4) begin
                redirects++; // taken branch, JAL or ECALL
            end
        end
        if (redirects == 0) begin
            $display("the program never took a branch, a jump or a trap");
            $display("Test failed");
            $fatal(1, "no redirect exercised");
        end else begin
            $display("%0d retirements, %0d of them redirects", RETIRE_COUNT, redirects);
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule
